// File: common/adv_timer_cfg.svh
// Advanced timer configuration
`ifndef ADV_TIMER_CFG_SVH
`define ADV_TIMER_CFG_SVH

// Block dimensions
`define ATIM_N_TIMERS     4
`define ATIM_N_CH         4
`define ATIM_N_EVT        4
`define ATIM_CNT_W        16
`define ATIM_PRESC_W      8
`define ATIM_EVT_SEL_W    4

// APB address map
`define ATIM_ADDR_W       12
`define ATIM_TIMER_STRIDE 'h40

// Register offsets inside one timer block
`define ATIM_REG_CMD      6'h00
`define ATIM_REG_CFG      6'h04
`define ATIM_REG_TH       6'h08
`define ATIM_REG_CH0      6'h0C
`define ATIM_REG_CNT      6'h1C

// Global event register
`define ATIM_REG_EVT      12'h100

// Command register bits
`define ATIM_CMD_START    0
`define ATIM_CMD_STOP     1
`define ATIM_CMD_RST      2

`endif

// File: common/adv_timer_pkg.sv
// Advanced timer shared types
`include "adv_timer_cfg.svh"

package adv_timer_pkg;

	// Counter, start, end and threshold values
	typedef logic [`ATIM_CNT_W-1:0] cnt_t;

	// Prescaler reload value, the counter steps every presc+1 cycles
	typedef logic [`ATIM_PRESC_W-1:0] presc_t;

	// Compare channel behaviour
	typedef enum logic [1:0] {
		CMP_OFF     = 2'd0,
		CMP_SET     = 2'd1,
		CMP_TOGGLE  = 2'd2,
		CMP_SET_CLR = 2'd3
	} cmp_mode_e;

	// Index into the flat channel vector, entry 4t+c is channel c of timer t
	typedef logic [`ATIM_EVT_SEL_W-1:0] evt_sel_t;

endpackage

// File: hw/adv_timer_apb_regs.sv
// Advanced timer APB registers
`include "adv_timer_cfg.svh"

module adv_timer_apb_regs
	import adv_timer_pkg::*;
(
	input  logic                         HCLK,
	input  logic                         HRESETn,
	input  logic [`ATIM_ADDR_W-1:0]      paddr_i,
	input  logic [31:0]                  pwdata_i,
	input  logic                         pwrite_i,
	input  logic                         psel_i,
	input  logic                         penable_i,
	output logic [31:0]                  prdata_o,
	output logic                         pready_o,
	output logic                         pslverr_o,

	output logic [`ATIM_N_TIMERS-1:0]    start_o,
	output logic [`ATIM_N_TIMERS-1:0]    stop_o,
	output logic [`ATIM_N_TIMERS-1:0]    rst_o,
	output logic [`ATIM_N_TIMERS-1:0]    saw_o,
	output presc_t                       presc_o [`ATIM_N_TIMERS],
	output cnt_t                         cnt_start_o [`ATIM_N_TIMERS],
	output cnt_t                         cnt_end_o [`ATIM_N_TIMERS],
	output cnt_t                         ch_th_o [`ATIM_N_TIMERS][`ATIM_N_CH],
	output cmp_mode_e                    ch_mode_o [`ATIM_N_TIMERS][`ATIM_N_CH],
	input  cnt_t                         count_i [`ATIM_N_TIMERS],

	output evt_sel_t                     evt_sel_o [`ATIM_N_EVT],
	output logic [`ATIM_N_EVT-1:0]       evt_en_o
);

	localparam int OFF_W  = $clog2(`ATIM_TIMER_STRIDE);
	localparam int TIDX_W = $clog2(`ATIM_N_TIMERS);
	localparam int CH_W   = $clog2(`ATIM_N_CH);

	logic              access;
	logic              wr_en;
	logic              is_timer;
	logic              is_evt;
	logic              reg_ok;
	logic              ch_hit;
	logic [TIDX_W-1:0] tim_idx;
	logic [OFF_W-1:0]  reg_off;
	logic [CH_W-1:0]   ch_idx;

	////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////

	assign access   = psel_i & penable_i;
	assign is_timer = paddr_i < `ATIM_ADDR_W'(`ATIM_N_TIMERS * `ATIM_TIMER_STRIDE);
	assign is_evt   = paddr_i == `ATIM_REG_EVT;
	assign tim_idx  = paddr_i[OFF_W +: TIDX_W];
	assign reg_off  = paddr_i[OFF_W-1:0];

	always_comb begin
		reg_ok = 1'b0;
		ch_hit = 1'b0;
		ch_idx = '0;
		if (is_evt) begin
			reg_ok = 1'b1;
		end else if (is_timer) begin
			case (reg_off)
				`ATIM_REG_CMD, `ATIM_REG_CFG, `ATIM_REG_TH, `ATIM_REG_CNT: reg_ok = 1'b1;
				default: begin
					// Channel registers sit one word apart after CH0
					for (int c = 0; c < `ATIM_N_CH; c++) begin
						if (reg_off == OFF_W'(`ATIM_REG_CH0 + 4 * c)) begin
							reg_ok = 1'b1;
							ch_hit = 1'b1;
							ch_idx = CH_W'(c);
						end
					end
				end
			endcase
		end
	end

	assign wr_en     = access & pwrite_i & reg_ok;
	assign pready_o  = 1'b1;
	assign pslverr_o = access & ~reg_ok;

	////////////////////////////////////////////////////////////
	// Register writes and command pulses
	////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			start_o  <= '0;
			stop_o   <= '0;
			rst_o    <= '0;
			saw_o    <= '0;
			evt_en_o <= '0;
			for (int t = 0; t < `ATIM_N_TIMERS; t++) begin
				presc_o[t]     <= '0;
				cnt_start_o[t] <= '0;
				cnt_end_o[t]   <= '0;
				for (int c = 0; c < `ATIM_N_CH; c++) begin
					ch_th_o[t][c]   <= '0;
					ch_mode_o[t][c] <= CMP_OFF;
				end
			end
			for (int e = 0; e < `ATIM_N_EVT; e++) begin
				evt_sel_o[e] <= '0;
			end
		end else begin
			// Commands are single-cycle strobes
			start_o <= '0;
			stop_o  <= '0;
			rst_o   <= '0;
			if (wr_en && is_evt) begin
				for (int e = 0; e < `ATIM_N_EVT; e++) begin
					evt_sel_o[e] <= pwdata_i[`ATIM_EVT_SEL_W*e +: `ATIM_EVT_SEL_W];
				end
				evt_en_o <= pwdata_i[16 +: `ATIM_N_EVT];
			end else if (wr_en) begin
				case (reg_off)
					`ATIM_REG_CMD: begin
						start_o[tim_idx] <= pwdata_i[`ATIM_CMD_START];
						stop_o[tim_idx]  <= pwdata_i[`ATIM_CMD_STOP];
						rst_o[tim_idx]   <= pwdata_i[`ATIM_CMD_RST];
					end
					`ATIM_REG_CFG: begin
						saw_o[tim_idx]   <= pwdata_i[0];
						presc_o[tim_idx] <= pwdata_i[15:8];
					end
					`ATIM_REG_TH: begin
						cnt_start_o[tim_idx] <= pwdata_i[15:0];
						cnt_end_o[tim_idx]   <= pwdata_i[31:16];
					end
					default: begin
						if (ch_hit) begin
							ch_th_o[tim_idx][ch_idx]   <= pwdata_i[15:0];
							ch_mode_o[tim_idx][ch_idx] <= cmp_mode_e'(pwdata_i[17:16]);
						end
					end
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Read mux
	////////////////////////////////////////////////////////////

	always_comb begin
		prdata_o = '0;
		if (is_evt) begin
			for (int e = 0; e < `ATIM_N_EVT; e++) begin
				prdata_o[`ATIM_EVT_SEL_W*e +: `ATIM_EVT_SEL_W] = evt_sel_o[e];
			end
			prdata_o[16 +: `ATIM_N_EVT] = evt_en_o;
		end else if (is_timer) begin
			case (reg_off)
				`ATIM_REG_CFG: begin
					prdata_o[0]    = saw_o[tim_idx];
					prdata_o[15:8] = presc_o[tim_idx];
				end
				`ATIM_REG_TH: begin
					prdata_o[15:0]  = cnt_start_o[tim_idx];
					prdata_o[31:16] = cnt_end_o[tim_idx];
				end
				`ATIM_REG_CNT: prdata_o[15:0] = count_i[tim_idx];
				default: begin
					// CMD falls through here and reads as zero
					if (ch_hit) begin
						prdata_o[15:0]  = ch_th_o[tim_idx][ch_idx];
						prdata_o[17:16] = ch_mode_o[tim_idx][ch_idx];
					end
				end
			endcase
		end
	end

	// An error response belongs to the access phase of a proper setup/access pair
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		pslverr_o |-> penable_i && $past(psel_i && !penable_i))
	else $error("pslverr_o raised outside an APB access phase");

	for (genvar t = 0; t < `ATIM_N_TIMERS; t++) begin : g_cmd_chk
		assert property (@(posedge HCLK) disable iff (!HRESETn)
			(start_o[t] || stop_o[t] || rst_o[t]) |=> !(start_o[t] || stop_o[t] || rst_o[t]))
		else $error("command pulse on timer %0d lasted two cycles", t);
	end

endmodule

// File: timer/timer_counter.sv
// Timer prescaler and counter
`include "adv_timer_cfg.svh"

module timer_counter
	import adv_timer_pkg::*;
(
	input  logic   HCLK,
	input  logic   HRESETn,
	input  logic   start_i,
	input  logic   stop_i,
	input  logic   rst_i,
	input  logic   saw_i,
	input  presc_t presc_i,
	input  cnt_t   cnt_start_i,
	input  cnt_t   cnt_end_i,
	output cnt_t   count_o,
	output logic   tick_o,
	output logic   at_end_o
);

	logic   running_q;
	logic   dir_up_q;
	logic   tick_q;
	presc_t presc_cnt_q;
	cnt_t   count_q;
	logic   step;
	logic   dir_up_nxt;
	cnt_t   count_nxt;
	logic   in_range;

	// A lowered prescale value must not strand the divider above it
	assign step = running_q && (presc_cnt_q >= presc_i);

	always_comb begin
		count_nxt  = count_q;
		dir_up_nxt = dir_up_q;
		if (saw_i) begin
			dir_up_nxt = 1'b1;
			if (count_q >= cnt_end_i || count_q < cnt_start_i)
				count_nxt = cnt_start_i;
			else
				count_nxt = count_q + 1'b1;
		end else if (dir_up_q) begin
			if (count_q >= cnt_end_i) begin
				// Turn at the top, the end value is held for a single step
				dir_up_nxt = 1'b0;
				if (count_q > cnt_start_i)
					count_nxt = count_q - 1'b1;
			end else begin
				count_nxt = count_q + 1'b1;
			end
		end else begin
			if (count_q <= cnt_start_i) begin
				dir_up_nxt = 1'b1;
				if (count_q < cnt_end_i)
					count_nxt = count_q + 1'b1;
			end else begin
				count_nxt = count_q - 1'b1;
			end
		end
	end

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			running_q   <= 1'b0;
			dir_up_q    <= 1'b1;
			tick_q      <= 1'b0;
			presc_cnt_q <= '0;
			count_q     <= '0;
		end else begin
			tick_q <= 1'b0;
			if (stop_i)
				running_q <= 1'b0;
			else if (start_i)
				running_q <= 1'b1;
			if (rst_i) begin
				count_q     <= cnt_start_i;
				presc_cnt_q <= '0;
				dir_up_q    <= 1'b1;
			end else if (step) begin
				presc_cnt_q <= '0;
				count_q     <= count_nxt;
				dir_up_q    <= dir_up_nxt;
				tick_q      <= 1'b1;
			end else if (running_q) begin
				presc_cnt_q <= presc_cnt_q + 1'b1;
			end
		end
	end

	// The tick lines up with the cycle in which the new count is visible
	assign count_o  = count_q;
	assign tick_o   = tick_q;
	assign at_end_o = count_q == cnt_end_i;

	assign in_range = (count_q >= cnt_start_i) && (count_q <= cnt_end_i);

	// Once inside the window the count never leaves it while the window is held
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		(running_q && in_range) ##1 ($stable(cnt_start_i) && $stable(cnt_end_i)) |-> in_range)
	else $error("count %0h left window [%0h, %0h]", count_q, cnt_start_i, cnt_end_i);

endmodule

// File: timer/timer_channel.sv
// Timer compare channel
`include "adv_timer_cfg.svh"

module timer_channel
	import adv_timer_pkg::*;
(
	input  logic      HCLK,
	input  logic      HRESETn,
	input  logic      rst_i,
	input  logic      tick_i,
	input  logic      at_end_i,
	input  cnt_t      count_i,
	input  cnt_t      th_i,
	input  cmp_mode_e mode_i,
	output logic      pwm_o
);

	logic pwm_q;
	logic end_seen_q;
	logic match;

	assign match = tick_i && (count_i == th_i);

	// In SET_CLR the clear lands on the step after the end value, so the
	// end value itself still counts as part of the high phase
	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			pwm_q      <= 1'b0;
			end_seen_q <= 1'b0;
		end else if (rst_i) begin
			pwm_q      <= 1'b0;
			end_seen_q <= 1'b0;
		end else begin
			if (tick_i)
				end_seen_q <= at_end_i;
			case (mode_i)
				CMP_OFF: pwm_q <= 1'b0;
				CMP_SET: begin
					if (match)
						pwm_q <= 1'b1;
				end
				CMP_TOGGLE: begin
					if (match)
						pwm_q <= ~pwm_q;
				end
				CMP_SET_CLR: begin
					if (match)
						pwm_q <= 1'b1;
					else if (tick_i && end_seen_q)
						pwm_q <= 1'b0;
				end
			endcase
		end
	end

	assign pwm_o = pwm_q;

endmodule

// File: hw/adv_timer_events.sv
// Advanced timer event generator
`include "adv_timer_cfg.svh"

module adv_timer_events
	import adv_timer_pkg::*;
(
	input  logic                                  HCLK,
	input  logic                                  HRESETn,
	input  logic [`ATIM_N_TIMERS*`ATIM_N_CH-1:0]  ch_i,
	input  evt_sel_t                              evt_sel_i [`ATIM_N_EVT],
	input  logic [`ATIM_N_EVT-1:0]                evt_en_i,
	output logic [`ATIM_N_EVT-1:0]                events_o
);

	// Bit 1 holds the newest sample, bit 0 the one before
	logic [1:0] sync_q [`ATIM_N_EVT];

	always_ff @(posedge HCLK or negedge HRESETn) begin
		if (!HRESETn) begin
			for (int e = 0; e < `ATIM_N_EVT; e++)
				sync_q[e] <= '0;
		end else begin
			for (int e = 0; e < `ATIM_N_EVT; e++) begin
				if (evt_en_i[e])
					sync_q[e] <= {ch_i[evt_sel_i[e]], sync_q[e][1]};
			end
		end
	end

	always_comb begin
		for (int e = 0; e < `ATIM_N_EVT; e++)
			events_o[e] = evt_en_i[e] & sync_q[e][1] & ~sync_q[e][0];
	end

	for (genvar e = 0; e < `ATIM_N_EVT; e++) begin : g_evt_chk
		assert property (@(posedge HCLK) disable iff (!HRESETn)
			events_o[e] |=> !events_o[e])
		else $error("event %0d pulse lasted two cycles", e);
	end

endmodule

// File: hw/apb_adv_timer.sv
// APB advanced PWM timer
`include "adv_timer_cfg.svh"

module apb_adv_timer
	import adv_timer_pkg::*;
(
	input  logic                    HCLK,
	input  logic                    HRESETn,
	input  logic [`ATIM_ADDR_W-1:0] paddr_i,
	input  logic [31:0]             pwdata_i,
	input  logic                    pwrite_i,
	input  logic                    psel_i,
	input  logic                    penable_i,
	output logic [31:0]             prdata_o,
	output logic                    pready_o,
	output logic                    pslverr_o,
	output logic [`ATIM_N_EVT-1:0]  events_o,
	output logic [`ATIM_N_CH-1:0]   ch_0_o,
	output logic [`ATIM_N_CH-1:0]   ch_1_o,
	output logic [`ATIM_N_CH-1:0]   ch_2_o,
	output logic [`ATIM_N_CH-1:0]   ch_3_o
);

	logic [`ATIM_N_TIMERS-1:0]           start;
	logic [`ATIM_N_TIMERS-1:0]           stop;
	logic [`ATIM_N_TIMERS-1:0]           rst;
	logic [`ATIM_N_TIMERS-1:0]           saw;
	logic [`ATIM_N_TIMERS-1:0]           tick;
	logic [`ATIM_N_TIMERS-1:0]           at_end;
	presc_t                              presc [`ATIM_N_TIMERS];
	cnt_t                                cnt_start [`ATIM_N_TIMERS];
	cnt_t                                cnt_end [`ATIM_N_TIMERS];
	cnt_t                                count [`ATIM_N_TIMERS];
	cnt_t                                ch_th [`ATIM_N_TIMERS][`ATIM_N_CH];
	cmp_mode_e                           ch_mode [`ATIM_N_TIMERS][`ATIM_N_CH];
	evt_sel_t                            evt_sel [`ATIM_N_EVT];
	logic [`ATIM_N_EVT-1:0]              evt_en;
	logic [`ATIM_N_CH-1:0]               pwm [`ATIM_N_TIMERS];
	logic [`ATIM_N_TIMERS*`ATIM_N_CH-1:0] ch_all;

	adv_timer_apb_regs u_regs (
		.HCLK        ( HCLK      ),
		.HRESETn     ( HRESETn   ),
		.paddr_i     ( paddr_i   ),
		.pwdata_i    ( pwdata_i  ),
		.pwrite_i    ( pwrite_i  ),
		.psel_i      ( psel_i    ),
		.penable_i   ( penable_i ),
		.prdata_o    ( prdata_o  ),
		.pready_o    ( pready_o  ),
		.pslverr_o   ( pslverr_o ),
		.start_o     ( start     ),
		.stop_o      ( stop      ),
		.rst_o       ( rst       ),
		.saw_o       ( saw       ),
		.presc_o     ( presc     ),
		.cnt_start_o ( cnt_start ),
		.cnt_end_o   ( cnt_end   ),
		.ch_th_o     ( ch_th     ),
		.ch_mode_o   ( ch_mode   ),
		.count_i     ( count     ),
		.evt_sel_o   ( evt_sel   ),
		.evt_en_o    ( evt_en    )
	);

	////////////////////////////////////////////////////////////
	// Timers and their compare channels
	////////////////////////////////////////////////////////////

	for (genvar t = 0; t < `ATIM_N_TIMERS; t++) begin : g_tim
		timer_counter u_cnt (
			.HCLK        ( HCLK         ),
			.HRESETn     ( HRESETn      ),
			.start_i     ( start[t]     ),
			.stop_i      ( stop[t]      ),
			.rst_i       ( rst[t]       ),
			.saw_i       ( saw[t]       ),
			.presc_i     ( presc[t]     ),
			.cnt_start_i ( cnt_start[t] ),
			.cnt_end_i   ( cnt_end[t]   ),
			.count_o     ( count[t]     ),
			.tick_o      ( tick[t]      ),
			.at_end_o    ( at_end[t]    )
		);

		for (genvar c = 0; c < `ATIM_N_CH; c++) begin : g_ch
			timer_channel u_ch (
				.HCLK     ( HCLK          ),
				.HRESETn  ( HRESETn       ),
				.rst_i    ( rst[t]        ),
				.tick_i   ( tick[t]       ),
				.at_end_i ( at_end[t]     ),
				.count_i  ( count[t]      ),
				.th_i     ( ch_th[t][c]   ),
				.mode_i   ( ch_mode[t][c] ),
				.pwm_o    ( pwm[t][c]     )
			);
		end

		assign ch_all[t*`ATIM_N_CH +: `ATIM_N_CH] = pwm[t];
	end

	assign ch_0_o = pwm[0];
	assign ch_1_o = pwm[1];
	assign ch_2_o = pwm[2];
	assign ch_3_o = pwm[3];

	adv_timer_events u_events (
		.HCLK      ( HCLK     ),
		.HRESETn   ( HRESETn  ),
		.ch_i      ( ch_all   ),
		.evt_sel_i ( evt_sel  ),
		.evt_en_i  ( evt_en   ),
		.events_o  ( events_o )
	);

endmodule

// File: sim/tb_apb_adv_timer.sv
// APB advanced timer testbench
`include "adv_timer_cfg.svh"

module tb_apb_adv_timer
	import adv_timer_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD = 20;
	localparam int SAMPLE_DLY  = 5;
	localparam int APB_CYC     = 3;

	// Cycle budget per test, from access counts and PWM periods
	localparam int LEN_RESET   = 8;
	localparam int LEN_REGS    = 67 * APB_CYC;
	localparam int LEN_CNT     = 27 * APB_CYC + 16 * 7 + 50;
	localparam int LEN_SAW     = 4 * APB_CYC + 4 * 20;
	localparam int LEN_MODES   = 7 * APB_CYC + 8 * 10;
	localparam int LEN_UPDN    = 4 * APB_CYC + 5 * 20;
	localparam int LEN_EVT     = APB_CYC + 3 + 3 * 22;
	localparam int CYCLE_LIMIT = LEN_RESET + LEN_REGS + LEN_CNT + LEN_SAW + LEN_MODES
		+ LEN_UPDN + LEN_EVT + 200;

	localparam logic [31:0] CMD_START = 32'h1 << `ATIM_CMD_START;
	localparam logic [31:0] CMD_STOP  = 32'h1 << `ATIM_CMD_STOP;
	localparam logic [31:0] CMD_RST   = 32'h1 << `ATIM_CMD_RST;

	logic                    HCLK = 1'b0;
	logic                    HRESETn;
	logic [`ATIM_ADDR_W-1:0] paddr;
	logic [31:0]             pwdata;
	logic                    pwrite;
	logic                    psel;
	logic                    penable;
	logic [31:0]             prdata;
	logic                    pready;
	logic                    pslverr;
	logic [3:0]              events;
	logic [3:0]              ch_0;
	logic [3:0]              ch_1;
	logic [3:0]              ch_2;
	logic [3:0]              ch_3;
	logic [15:0]             ch_all;

	logic [15:0] lfsr_q;
	int          cycle_cnt = 0;
	int          errors;
	int          errors_seen;
	int          tests_run;
	int          tests_failed;

	assign ch_all = {ch_3, ch_2, ch_1, ch_0};

	apb_adv_timer dut0 (
		.HCLK      ( HCLK    ),
		.HRESETn   ( HRESETn ),
		.paddr_i   ( paddr   ),
		.pwdata_i  ( pwdata  ),
		.pwrite_i  ( pwrite  ),
		.psel_i    ( psel    ),
		.penable_i ( penable ),
		.prdata_o  ( prdata  ),
		.pready_o  ( pready  ),
		.pslverr_o ( pslverr ),
		.events_o  ( events  ),
		.ch_0_o    ( ch_0    ),
		.ch_1_o    ( ch_1    ),
		.ch_2_o    ( ch_2    ),
		.ch_3_o    ( ch_3    )
	);

	always #(HALF_PERIOD) HCLK = ~HCLK;

	always @(posedge HCLK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Errors found");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	// Taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic next_random(input int n_bits, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n_bits; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			value  = {value[30:0], lfsr_q[0]};
		end
	endtask

	function automatic logic [`ATIM_ADDR_W-1:0] reg_addr(input int t, input int off);
		return `ATIM_ADDR_W'(t * `ATIM_TIMER_STRIDE + off);
	endfunction

	function automatic logic [31:0] th_word(input int s, input int e);
		return {16'(e), 16'(s)};
	endfunction

	function automatic logic [31:0] cfg_word(input logic saw, input int presc);
		return {16'h0, 8'(presc), 7'h0, saw};
	endfunction

	function automatic logic [31:0] ch_word(input cmp_mode_e mode, input int th);
		return {14'h0, 2'(mode), 16'(th)};
	endfunction

	function automatic int saw_period(input int s, input int e, input int presc);
		return (e - s + 1) * (presc + 1);
	endfunction

	function automatic int updown_period(input int s, input int e, input int presc);
		return 2 * (e - s) * (presc + 1);
	endfunction

	task automatic note_mismatch(input string msg);
		errors++;
		$display("Mismatch at %0t: %s", $time, msg);
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors != errors_seen)
			tests_failed++;
		$display("Test %0d (%s) finished with %0d mismatch(es)", tests_run, name,
			errors - errors_seen);
		errors_seen = errors;
	endtask

	task automatic write_reg(input logic [`ATIM_ADDR_W-1:0] addr, input logic [31:0] data);
		@(negedge HCLK);
		paddr   = addr;
		pwdata  = data;
		pwrite  = 1'b1;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge HCLK);
		penable = 1'b1;
		#(SAMPLE_DLY);
		assert (pready === 1'b1) else note_mismatch($sformatf("pready low writing %0h", addr));
		assert (pslverr === 1'b0) else note_mismatch($sformatf("pslverr writing %0h", addr));
		@(negedge HCLK);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic read_reg(input logic [`ATIM_ADDR_W-1:0] addr, output logic [31:0] data,
		output logic err);
		@(negedge HCLK);
		paddr   = addr;
		pwrite  = 1'b0;
		psel    = 1'b1;
		penable = 1'b0;
		@(negedge HCLK);
		penable = 1'b1;
		#(SAMPLE_DLY);
		assert (pready === 1'b1) else note_mismatch($sformatf("pready low reading %0h", addr));
		data = prdata;
		err  = pslverr;
		@(negedge HCLK);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic expect_read(input logic [`ATIM_ADDR_W-1:0] addr, input logic [31:0] exp,
		input string what);
		logic [31:0] data;
		logic        err;
		read_reg(addr, data, err);
		assert (data === exp)
		else note_mismatch($sformatf("%s at %0h read %0h, expected %0h", what, addr, data, exp));
		assert (err === 1'b0) else note_mismatch($sformatf("%s at %0h gave pslverr", what, addr));
	endtask

	// Cycle number of the next change of channel idx to the given level
	task automatic wait_edge(input int idx, input logic level, output int at_cycle);
		logic prev;
		prev = ch_all[idx];
		@(negedge HCLK);
		while (prev == level || ch_all[idx] != level) begin
			prev = ch_all[idx];
			@(negedge HCLK);
		end
		at_cycle = cycle_cnt;
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic test_registers();
		logic [31:0] value;
		logic [31:0] data;
		logic        err;
		for (int t = 0; t < `ATIM_N_TIMERS; t++) begin
			expect_read(reg_addr(t, `ATIM_REG_TH), 32'h0, "TH after reset");
			expect_read(reg_addr(t, `ATIM_REG_CNT), 32'h0, "count after reset");
			next_random(32, value);
			write_reg(reg_addr(t, `ATIM_REG_TH), value);
			expect_read(reg_addr(t, `ATIM_REG_TH), value, "TH");
			next_random(32, value);
			write_reg(reg_addr(t, `ATIM_REG_CFG), value);
			expect_read(reg_addr(t, `ATIM_REG_CFG), value & 32'h0000_ff01, "CFG");
			for (int c = 0; c < `ATIM_N_CH; c++) begin
				next_random(32, value);
				write_reg(reg_addr(t, `ATIM_REG_CH0 + 4 * c), value);
				expect_read(reg_addr(t, `ATIM_REG_CH0 + 4 * c), value & 32'h0003_ffff, "channel");
			end
			expect_read(reg_addr(t, `ATIM_REG_CMD), 32'h0, "CMD");
			read_reg(reg_addr(t, 'h20), data, err);
			assert (err === 1'b1) else note_mismatch($sformatf("no pslverr on timer %0d offset 20", t));
		end
		next_random(32, value);
		write_reg(`ATIM_REG_EVT, value);
		expect_read(`ATIM_REG_EVT, value & 32'h000f_ffff, "EVT");
		read_reg(`ATIM_REG_EVT + 'h4, data, err);
		assert (err === 1'b1) else note_mismatch("no pslverr above the event register");
	endtask

	task automatic test_counter();
		int          s = 10;
		int          e = 40;
		logic [31:0] data;
		logic [31:0] frozen;
		logic [31:0] gap;
		logic        err;
		write_reg(reg_addr(1, `ATIM_REG_TH), th_word(s, e));
		write_reg(reg_addr(1, `ATIM_REG_CFG), cfg_word(1'b1, 2));
		write_reg(reg_addr(1, `ATIM_REG_CH0), ch_word(CMP_SET, 20));
		write_reg(reg_addr(1, `ATIM_REG_CMD), CMD_RST);
		expect_read(reg_addr(1, `ATIM_REG_CNT), 32'(s), "count after rst");
		write_reg(reg_addr(1, `ATIM_REG_CMD), CMD_START);
		for (int i = 0; i < 16; i++) begin
			next_random(3, gap);
			repeat (int'(gap)) @(negedge HCLK);
			read_reg(reg_addr(1, `ATIM_REG_CNT), data, err);
			assert (data >= 32'(s) && data <= 32'(e))
			else note_mismatch($sformatf("count %0d outside [%0d, %0d]", data, s, e));
		end
		// The count has passed 20 by now, so the SET channel must be high
		assert (ch_1[0] === 1'b1) else note_mismatch("timer 1 SET channel low while counting");
		write_reg(reg_addr(1, `ATIM_REG_CMD), CMD_STOP);
		read_reg(reg_addr(1, `ATIM_REG_CNT), frozen, err);
		repeat (50) @(negedge HCLK);
		expect_read(reg_addr(1, `ATIM_REG_CNT), frozen, "count after stop");
		write_reg(reg_addr(1, `ATIM_REG_CMD), CMD_RST);
		expect_read(reg_addr(1, `ATIM_REG_CNT), 32'(s), "count after second rst");
		assert (ch_1 === 4'b0000)
		else note_mismatch($sformatf("timer 1 channels %b after rst", ch_1));
	endtask

	task automatic test_saw_pwm();
		int s = 3;
		int e = 12;
		int p = 1;
		int th = 8;
		int r0;
		int r1;
		int r2;
		int f0;
		int f1;
		write_reg(reg_addr(2, `ATIM_REG_TH), th_word(s, e));
		write_reg(reg_addr(2, `ATIM_REG_CFG), cfg_word(1'b1, p));
		write_reg(reg_addr(2, `ATIM_REG_CH0), ch_word(CMP_SET_CLR, th));
		write_reg(reg_addr(2, `ATIM_REG_CMD), CMD_RST | CMD_START);
		wait_edge(8, 1'b1, r0);
		wait_edge(8, 1'b0, f0);
		wait_edge(8, 1'b1, r1);
		wait_edge(8, 1'b0, f1);
		wait_edge(8, 1'b1, r2);
		assert (r1 - r0 == saw_period(s, e, p) && r2 - r1 == saw_period(s, e, p))
		else note_mismatch($sformatf("rise spacing %0d and %0d", r1 - r0, r2 - r1));
		assert (f1 - f0 == saw_period(s, e, p))
		else note_mismatch($sformatf("fall spacing %0d", f1 - f0));
		assert (f0 - r0 == (e - th + 1) * (p + 1))
		else note_mismatch($sformatf("high time %0d", f0 - r0));
	endtask

	task automatic test_modes();
		int period;
		int r0;
		int r1;
		int f0;
		period = saw_period(0, 9, 0);
		write_reg(reg_addr(3, `ATIM_REG_TH), th_word(0, 9));
		write_reg(reg_addr(3, `ATIM_REG_CFG), cfg_word(1'b1, 0));
		write_reg(reg_addr(3, `ATIM_REG_CH0), ch_word(CMP_TOGGLE, 5));
		write_reg(reg_addr(3, `ATIM_REG_CH0 + 4), ch_word(CMP_SET, 7));
		write_reg(reg_addr(3, `ATIM_REG_CH0 + 8), ch_word(CMP_OFF, 3));
		write_reg(reg_addr(3, `ATIM_REG_CMD), CMD_RST | CMD_START);
		wait_edge(12, 1'b1, r0);
		wait_edge(12, 1'b0, f0);
		wait_edge(12, 1'b1, r1);
		assert (f0 - r0 == period && r1 - f0 == period)
		else note_mismatch($sformatf("toggle spacing %0d and %0d", f0 - r0, r1 - f0));
		repeat (3 * period) begin
			@(negedge HCLK);
			assert (ch_all[13] === 1'b1) else note_mismatch("SET channel low before rst");
			assert (ch_all[14] === 1'b0) else note_mismatch("OFF channel went high");
		end
		write_reg(reg_addr(3, `ATIM_REG_CMD), CMD_STOP | CMD_RST);
		repeat (2 * period) begin
			@(negedge HCLK);
			assert (ch_all[14:12] === 3'b000)
			else note_mismatch($sformatf("channels %b after rst", ch_all[14:12]));
		end
	endtask

	task automatic test_updown();
		int period;
		int r0;
		int r1;
		int r2;
		int r3;
		period = updown_period(2, 7, 1);
		write_reg(reg_addr(0, `ATIM_REG_TH), th_word(2, 7));
		write_reg(reg_addr(0, `ATIM_REG_CFG), cfg_word(1'b0, 1));
		write_reg(reg_addr(0, `ATIM_REG_CH0), ch_word(CMP_SET_CLR, 5));
		write_reg(reg_addr(0, `ATIM_REG_CMD), CMD_RST | CMD_START);
		// The first rise comes from the upward pass after rst and is not periodic
		wait_edge(0, 1'b1, r0);
		wait_edge(0, 1'b1, r1);
		wait_edge(0, 1'b1, r2);
		wait_edge(0, 1'b1, r3);
		assert (r2 - r1 == period && r3 - r2 == period)
		else note_mismatch($sformatf("up-down rise spacing %0d and %0d", r2 - r1, r3 - r2));
	endtask

	task automatic test_events();
		int at_cycle;
		// Events 0 and 1 both select timer 2 channel 0, only event 0 is enabled
		write_reg(`ATIM_REG_EVT, 32'h0001_0088);
		repeat (3) @(negedge HCLK);
		for (int k = 0; k < 3; k++) begin
			wait_edge(8, 1'b1, at_cycle);
			assert (events === 4'b0000)
			else note_mismatch($sformatf("events %b in the cycle of the edge", events));
			@(negedge HCLK);
			assert (events === 4'b0001)
			else note_mismatch($sformatf("events %b one cycle after the edge", events));
			@(negedge HCLK);
			assert (events === 4'b0000)
			else note_mismatch($sformatf("events %b two cycles after the edge", events));
		end
	endtask

	initial begin
		HRESETn      = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		pwrite       = 1'b0;
		psel         = 1'b0;
		penable      = 1'b0;
		lfsr_q       = 16'd59;
		errors       = 0;
		errors_seen  = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (LEN_RESET) @(negedge HCLK);
		HRESETn = 1'b1;

		test_registers();
		end_test("registers");
		test_counter();
		end_test("counter");
		test_saw_pwm();
		end_test("sawtooth SET_CLR");
		test_modes();
		end_test("TOGGLE, SET and OFF");
		test_updown();
		end_test("up-down SET_CLR");
		test_events();
		end_test("events");

		$display("Tests run %0d, tests failed %0d, mismatches %0d", tests_run, tests_failed,
			errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: apb_adv_timer.f
+incdir+common
common/adv_timer_pkg.sv
hw/adv_timer_apb_regs.sv
timer/timer_counter.sv
timer/timer_channel.sv
hw/adv_timer_events.sv
hw/apb_adv_timer.sv
sim/tb_apb_adv_timer.sv

// File: Makefile
# Verilator simulation of the APB advanced timer

VERILATOR ?= verilator
TOP       ?= tb_apb_adv_timer
FLIST     ?= apb_adv_timer.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FLIST)) $(wildcard common/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# The log decides the result, the simulator's own exit status is not used
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
